// File: common/minimig_glue_pkg.sv
package minimig_glue_pkg;

	////////////////////////////////////////
	// Widths and timing
	////////////////////////////////////////

	localparam int CHANNEL_WIDTH    = 8;       // Internal colour channel
	localparam int VGA_WIDTH        = 6;       // Output colour channel
	localparam int OSD_BITS         = 2;       // Top bits replaced by OSD
	localparam int KEY_WIDTH        = 8;       // Scan code
	localparam int SAMPLE_WIDTH     = 16;      // Aux audio word
	localparam int AUD_FRAME_CYCLES = 2572;    // About 44.6 kHz at 114.75 MHz
	localparam int AUD_GAP_CYCLES   = 4;       // Left pop to right pop
	localparam int AUD_CNT_WIDTH    = $clog2(AUD_FRAME_CYCLES);
	localparam int AUD_GAP_WIDTH    = $clog2(AUD_GAP_CYCLES);
	localparam int PIX_DIV_31K      = 8;       // Pixel enable period, 31 kHz
	localparam int PIX_DIV_15K      = 4;       // Pixel enable period, 15 kHz
	localparam int PIX_DIV_WIDTH    = $clog2(PIX_DIV_31K);

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef logic [CHANNEL_WIDTH-1:0] channel_t;
	typedef logic [VGA_WIDTH-1:0]     vga_channel_t;
	typedef logic [OSD_BITS-1:0]      osd_bits_t;
	typedef logic [KEY_WIDTH-1:0]     key_code_t;
	typedef logic [SAMPLE_WIDTH-1:0]  sample_t;
	typedef logic [AUD_CNT_WIDTH-1:0] aud_cnt_t;
	typedef logic [AUD_GAP_WIDTH-1:0] aud_gap_t;
	typedef logic [PIX_DIV_WIDTH-1:0] pix_div_t;

	typedef struct packed {
		channel_t r;
		channel_t g;
		channel_t b;
	} rgb_t;

	typedef struct packed {
		vga_channel_t r;
		vga_channel_t g;
		vga_channel_t b;
	} vga_rgb_t;

	typedef struct packed {
		logic hs;
		logic vs;
	} sync_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	typedef enum logic [1:0] {
		AUD_IDLE,
		AUD_POP_LEFT,
		AUD_GAP,
		AUD_POP_RIGHT
	} aud_state_t;

endpackage

// File: keyboard/kbd_event_merge.sv
`timescale 1ns/1ps

module kbd_event_merge (
	input  logic                        CLK_114,
	input  logic                        rst_n,
	input  minimig_glue_pkg::key_code_t c64_key,       // Translated C64 matrix key
	input  logic                        c64_key_stb,
	input  minimig_glue_pkg::key_code_t amiga_key,     // Docking station keyboard
	input  logic                        amiga_key_stb,
	input  logic                        clk7_en,       // 7 MHz enable level
	output minimig_glue_pkg::key_code_t kbd_data,
	output logic                        kbd_stb
);

	logic clk7_en_d;   // Previous enable level
	logic clk7_rise;   // First cycle of enable high
	logic pending;     // Key captured, strobe not yet sent
	logic key_any;

	assign clk7_rise = clk7_en & ~clk7_en_d;
	assign key_any   = c64_key_stb | amiga_key_stb;

	////////////////////////////////////////
	// Pending flag and strobe
	////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (!rst_n) begin
			clk7_en_d <= 1'b0;
			pending   <= 1'b0;
			kbd_stb   <= 1'b0;
		end else begin
			clk7_en_d <= clk7_en;
			kbd_stb   <= clk7_rise & pending;   // Single cycle on enable edge
			if (clk7_rise)
				pending <= 1'b0;
			if (key_any)
				pending <= 1'b1;                // New key wins over the clear
		end
	end

	// Code capture, C64 path has priority
	always_ff @(posedge CLK_114) begin
		if (key_any)
			kbd_data <= c64_key_stb ? c64_key : amiga_key;   // Later key overwrites
	end

endmodule

// File: audio/aux_audio_pacer.sv
`timescale 1ns/1ps

module aux_audio_pacer (
	input  logic                      CLK_114,
	input  logic                      rst_n,
	input  minimig_glue_pkg::sample_t aud_sample,   // FIFO head word
	output logic                      aud_next,     // FIFO pop pulse
	output minimig_glue_pkg::stereo_t aud_out
);

	minimig_glue_pkg::aud_cnt_t   frame_cnt;
	minimig_glue_pkg::aud_gap_t   gap_cnt;
	minimig_glue_pkg::aud_state_t state;
	logic                         frame_tick;

	// Samples arrive little endian from the host
	function automatic minimig_glue_pkg::sample_t byte_swap(
		input minimig_glue_pkg::sample_t s
	);
		return {s[7:0], s[15:8]};
	endfunction

	assign frame_tick = (frame_cnt == minimig_glue_pkg::aud_cnt_t'(
		minimig_glue_pkg::AUD_FRAME_CYCLES - 1));

	////////////////////////////////////////
	// Frame timer
	////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (!rst_n)
			frame_cnt <= '0;
		else if (frame_tick)
			frame_cnt <= '0;                  // Wrap once per stereo frame
		else
			frame_cnt <= frame_cnt + 1'b1;
	end

	////////////////////////////////////////
	// Pop sequencer
	////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (!rst_n) begin
			state   <= minimig_glue_pkg::AUD_IDLE;
			gap_cnt <= '0;
		end else begin
			case (state)
				minimig_glue_pkg::AUD_IDLE:
					if (frame_tick)
						state <= minimig_glue_pkg::AUD_POP_LEFT;
				minimig_glue_pkg::AUD_POP_LEFT: begin
					state   <= minimig_glue_pkg::AUD_GAP;
					gap_cnt <= minimig_glue_pkg::aud_gap_t'(
						minimig_glue_pkg::AUD_GAP_CYCLES - 2);   // Pop cycles excluded
				end
				minimig_glue_pkg::AUD_GAP:
					if (gap_cnt == '0)
						state <= minimig_glue_pkg::AUD_POP_RIGHT;
					else
						gap_cnt <= gap_cnt - 1'b1;
				default:
					state <= minimig_glue_pkg::AUD_IDLE;   // Right pop done
			endcase
		end
	end

	assign aud_next = (state == minimig_glue_pkg::AUD_POP_LEFT) |
		(state == minimig_glue_pkg::AUD_POP_RIGHT);

	// Stereo latch, one cycle behind the pop
	always_ff @(posedge CLK_114) begin
		if (!rst_n)
			aud_out <= '0;
		else if (state == minimig_glue_pkg::AUD_POP_LEFT)
			aud_out.left <= byte_swap(aud_sample);
		else if (state == minimig_glue_pkg::AUD_POP_RIGHT)
			aud_out.right <= byte_swap(aud_sample);
	end

endmodule

// File: video/osd_overlay.sv
`timescale 1ns/1ps

module osd_overlay (
	input  logic                   CLK_114,
	input  logic                   rst_n,
	input  minimig_glue_pkg::rgb_t  vid_rgb,     // Chipset colour
	input  minimig_glue_pkg::sync_t vid_sync,
	input  logic                   osd_window,  // OSD area active
	input  logic                   osd_pixel,   // OSD foreground
	output minimig_glue_pkg::rgb_t  mix_rgb,
	output minimig_glue_pkg::sync_t mix_sync
);

	minimig_glue_pkg::osd_bits_t osd_r;
	minimig_glue_pkg::osd_bits_t osd_g;
	minimig_glue_pkg::osd_bits_t osd_b;
	minimig_glue_pkg::rgb_t      mix_next;

	// OSD bits on top, source shifted down underneath
	function automatic minimig_glue_pkg::channel_t splice(
		input minimig_glue_pkg::channel_t  src,
		input minimig_glue_pkg::osd_bits_t osd
	);
		return {osd, src[minimig_glue_pkg::CHANNEL_WIDTH-1:minimig_glue_pkg::OSD_BITS]};
	endfunction

	// White text on a dark blue background
	assign osd_r = osd_pixel ? 2'b11 : 2'b00;
	assign osd_g = osd_pixel ? 2'b11 : 2'b00;
	assign osd_b = osd_pixel ? 2'b11 : 2'b10;

	always_comb begin
		mix_next = vid_rgb;                   // Outside window, pass through
		if (osd_window) begin
			mix_next.r = splice(vid_rgb.r, osd_r);
			mix_next.g = splice(vid_rgb.g, osd_g);
			mix_next.b = splice(vid_rgb.b, osd_b);
		end
	end

	// Colour and syncs registered together to stay aligned
	always_ff @(posedge CLK_114) begin
		if (!rst_n) begin
			mix_rgb  <= '0;
			mix_sync <= '0;
		end else begin
			mix_rgb  <= mix_next;
			mix_sync <= vid_sync;
		end
	end

endmodule

// File: video/vga_output_stage.sv
`timescale 1ns/1ps

module vga_output_stage (
	input  logic                       CLK_114,
	input  logic                       rst_n,
	input  minimig_glue_pkg::rgb_t     mix_rgb,
	input  minimig_glue_pkg::sync_t    mix_sync,
	input  logic                       scan_15k,       // Scandoubler off
	input  logic                       hsyncpol,
	input  logic                       vsyncpol,
	output minimig_glue_pkg::vga_rgb_t vga_rgb,
	output minimig_glue_pkg::sync_t    vga_sync,
	output logic                       vga_pixel_ena
);

	localparam int TOP = minimig_glue_pkg::CHANNEL_WIDTH - 1;

	minimig_glue_pkg::pix_div_t pix_div;
	minimig_glue_pkg::pix_div_t pix_step;
	minimig_glue_pkg::pix_div_t pix_next;

	////////////////////////////////////////
	// Pixel divider
	////////////////////////////////////////

	// Step of two in 15 kHz mode halves the period
	assign pix_step = scan_15k ?
		minimig_glue_pkg::pix_div_t'(minimig_glue_pkg::PIX_DIV_31K /
			minimig_glue_pkg::PIX_DIV_15K) :
		minimig_glue_pkg::pix_div_t'(1);

	// Low bits masked so the count lands on zero after a mode change
	assign pix_next = (pix_div & ~(pix_step - 1'b1)) + pix_step;

	always_ff @(posedge CLK_114) begin
		if (!rst_n) begin
			pix_div       <= '0;
			vga_pixel_ena <= 1'b0;
		end else begin
			pix_div       <= pix_next;
			vga_pixel_ena <= (pix_next == '0);   // One pulse per wrap
		end
	end

	////////////////////////////////////////
	// Sync polarity and colour
	////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (!rst_n) begin
			vga_sync <= '0;
			vga_rgb  <= '0;
		end else begin
			vga_sync.hs <= mix_sync.hs ^ hsyncpol;
			vga_sync.vs <= mix_sync.vs ^ vsyncpol;
			if (vga_pixel_ena) begin             // Colour held between pixels
				vga_rgb.r <= mix_rgb.r[TOP -: minimig_glue_pkg::VGA_WIDTH];
				vga_rgb.g <= mix_rgb.g[TOP -: minimig_glue_pkg::VGA_WIDTH];
				vga_rgb.b <= mix_rgb.b[TOP -: minimig_glue_pkg::VGA_WIDTH];
			end
		end
	end

endmodule

// File: verilog/minimig_glue_top.sv
`timescale 1ns/1ps

module minimig_glue_top (
	input  logic                        CLK_114,
	input  logic                        rst_n,

	// Keyboard sources
	input  minimig_glue_pkg::key_code_t c64_key,
	input  logic                        c64_key_stb,
	input  minimig_glue_pkg::key_code_t amiga_key,
	input  logic                        amiga_key_stb,
	input  logic                        clk7_en,
	output minimig_glue_pkg::key_code_t kbd_data,       // To chipset keyboard port
	output logic                        kbd_stb,

	// Aux audio FIFO
	input  minimig_glue_pkg::sample_t   aud_sample,
	output logic                        aud_next,
	output minimig_glue_pkg::stereo_t   aud_out,        // To Paula aux inputs

	// Video
	input  minimig_glue_pkg::rgb_t      vid_rgb,
	input  minimig_glue_pkg::sync_t     vid_sync,
	input  logic                        osd_window,
	input  logic                        osd_pixel,
	input  logic                        scan_15k,
	input  logic                        hsyncpol,
	input  logic                        vsyncpol,
	output minimig_glue_pkg::vga_rgb_t  vga_rgb,
	output minimig_glue_pkg::sync_t     vga_sync,
	output logic                        vga_pixel_ena
);

	minimig_glue_pkg::rgb_t  mix_rgb;    // Overlay to output stage
	minimig_glue_pkg::sync_t mix_sync;

	////////////////////////////////////////
	// Keyboard and audio
	////////////////////////////////////////

	kbd_event_merge u_kbd (
		.CLK_114       (CLK_114),
		.rst_n         (rst_n),
		.c64_key       (c64_key),
		.c64_key_stb   (c64_key_stb),
		.amiga_key     (amiga_key),
		.amiga_key_stb (amiga_key_stb),
		.clk7_en       (clk7_en),
		.kbd_data      (kbd_data),
		.kbd_stb       (kbd_stb)
	);

	aux_audio_pacer u_aud (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.aud_sample (aud_sample),
		.aud_next   (aud_next),
		.aud_out    (aud_out)
	);

	////////////////////////////////////////
	// Video path
	////////////////////////////////////////

	osd_overlay u_osd (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.vid_rgb    (vid_rgb),
		.vid_sync   (vid_sync),
		.osd_window (osd_window),
		.osd_pixel  (osd_pixel),
		.mix_rgb    (mix_rgb),
		.mix_sync   (mix_sync)
	);

	vga_output_stage u_vga (
		.CLK_114       (CLK_114),
		.rst_n         (rst_n),
		.mix_rgb       (mix_rgb),
		.mix_sync      (mix_sync),
		.scan_15k      (scan_15k),
		.hsyncpol      (hsyncpol),
		.vsyncpol      (vsyncpol),
		.vga_rgb       (vga_rgb),
		.vga_sync      (vga_sync),
		.vga_pixel_ena (vga_pixel_ena)
	);

endmodule

// File: testbench/minimig_glue_assertions.sv
`timescale 1ns/1ps

module minimig_glue_assertions (
	input logic CLK_114,
	input logic rst_n,
	input logic kbd_stb,         // Merged key strobe
	input logic aud_next,        // FIFO pop
	input logic vga_pixel_ena
);

	int failures = 0;            // Failed property count

	////////////////////////////////////////
	// Single cycle pulses
	////////////////////////////////////////

	a_kbd_stb_single : assert property (@(posedge CLK_114) disable iff (!rst_n)
		kbd_stb |=> !kbd_stb)
		else begin
			failures++;
			$error("kbd_stb stayed high for two cycles");
		end

	a_aud_next_single : assert property (@(posedge CLK_114) disable iff (!rst_n)
		aud_next |=> !aud_next)
		else begin
			failures++;
			$error("aud_next pulse longer than one cycle");
		end

	a_pixel_ena_single : assert property (@(posedge CLK_114) disable iff (!rst_n)
		vga_pixel_ena |=> !vga_pixel_ena)
		else begin
			failures++;
			$error("vga_pixel_ena high in two consecutive cycles");
		end

endmodule

bind minimig_glue_top minimig_glue_assertions u_assertions (
	.CLK_114       (CLK_114),
	.rst_n         (rst_n),
	.kbd_stb       (kbd_stb),
	.aud_next      (aud_next),
	.vga_pixel_ena (vga_pixel_ena)
);

// File: testbench/tb_minimig_glue.sv
`timescale 1ns/1ps

module tb_minimig_glue;

	typedef struct packed {
		logic [1:0]                  mode;       // 0 c64, 1 amiga, 2 both, 3 two keys
		minimig_glue_pkg::key_code_t key_a;
		minimig_glue_pkg::key_code_t key_b;
		logic [7:0]                  delay;      // Cycles until clk7_en rise
		minimig_glue_pkg::key_code_t expected;
	} key_rec_t;

	typedef struct packed {
		minimig_glue_pkg::rgb_t  rgb;
		minimig_glue_pkg::sync_t sync;
		logic                    window;
		logic                    pixel;
		logic                    scan_15k;
		logic                    hpol;
		logic                    vpol;
	} vid_rec_t;

	logic CLK_114;
	logic rst_n;
	minimig_glue_pkg::key_code_t c64_key;
	logic c64_key_stb;
	minimig_glue_pkg::key_code_t amiga_key;
	logic amiga_key_stb;
	logic clk7_en;
	minimig_glue_pkg::key_code_t kbd_data;
	logic kbd_stb;
	minimig_glue_pkg::sample_t aud_sample;
	logic aud_next;
	minimig_glue_pkg::stereo_t aud_out;
	minimig_glue_pkg::rgb_t vid_rgb;
	minimig_glue_pkg::sync_t vid_sync;
	logic osd_window;
	logic osd_pixel;
	logic scan_15k;
	logic hsyncpol;
	logic vsyncpol;
	minimig_glue_pkg::vga_rgb_t vga_rgb;
	minimig_glue_pkg::sync_t vga_sync;
	logic vga_pixel_ena;

	key_rec_t keys[$];
	vid_rec_t vids[$];
	minimig_glue_pkg::sample_t aud_words[$];    // Expected FIFO contents
	minimig_glue_pkg::sample_t fifo[$];         // FIFO model, head at index 0
	int errors = 0;
	int checks = 0;
	int cycle = 0;
	int release_cycle = 0;
	int limit = 0;
	bit trace_ok = 1'b1;
	bit trace_loaded = 1'b0;
	minimig_glue_pkg::sync_t prev_sync = '0;  // Last expected output sync
	logic prev_hpol = 1'b0;
	logic prev_vpol = 1'b0;

	minimig_glue_top u_dut (.*);

	initial begin
		CLK_114 = 1'b0;
		forever #10 CLK_114 = ~CLK_114;
	end

	initial begin
		forever begin
			@(posedge CLK_114);
			cycle++;
		end
	end

	// FIFO head moves on in the cycle after a pop
	initial begin : fifo_model
		bit pop_seen;
		pop_seen = 1'b0;
		aud_sample = '0;
		forever begin
			@(negedge CLK_114);
			if (rst_n) begin
				if (pop_seen && fifo.size() > 0)
					fifo.delete(0);
				pop_seen = aud_next;
			end
			aud_sample = (fifo.size() > 0) ? fifo[0] : '0;
		end
	end

	////////////////////////////////////////
	// Reference models and checks
	////////////////////////////////////////

	function automatic minimig_glue_pkg::sample_t swap_bytes(input minimig_glue_pkg::sample_t w);
		return 16'((w << 8) | (w >> 8));
	endfunction

	// Overlay then keep the top six bits of each channel
	function automatic minimig_glue_pkg::vga_rgb_t expected_vga(input vid_rec_t v);
		logic [7:0]  src [3];
		logic [7:0]  osd;
		logic [7:0]  mixed;
		logic [17:0] res;
		src[0] = v.rgb.r;
		src[1] = v.rgb.g;
		src[2] = v.rgb.b;
		res = '0;
		for (int i = 0; i < 3; i++) begin
			osd = v.pixel ? 8'd3 : ((i == 2) ? 8'd2 : 8'd0);   // Blue background
			mixed = v.window ? ((osd << 6) | (src[i] >> 2)) : src[i];
			res = {res[11:0], mixed[7:2]};
		end
		return res;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic load_trace();
		int fd;
		int rc;
		int mode;
		int delay;
		int f [7];
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] e;
		string line;
		string kind;
		fd = $fopen("testbench/glue_trace.txt", "r");
		if (fd == 0) begin
			$display("The trace file testbench/glue_trace.txt could not be opened");
			errors++;
			trace_ok = 1'b0;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			rc = $fgets(line, fd);
			if (line.len() < 3 || line[0] == "#")
				continue;                            // Blank or column notes
			rc = $sscanf(line, "%s", kind);
			if (kind == "key") begin
				rc = $sscanf(line, "%s %d %h %h %d %h", kind, mode, a, b, delay, e);
				keys.push_back({mode[1:0], a[7:0], b[7:0], delay[7:0], e[7:0]});
			end else if (kind == "aud") begin
				rc = $sscanf(line, "%s %h %h", kind, a, b);
				aud_words.push_back(a[15:0]);
				aud_words.push_back(b[15:0]);
			end else if (kind == "vid") begin
				rc = $sscanf(line, "%s %h %d %d %d %d %d %d %d", kind, a,
					f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
				vids.push_back({a[23:0], f[0][0], f[1][0], f[2][0], f[3][0],
					f[4][0], f[5][0], f[6][0]});
			end else begin
				$display("The trace file holds an unknown record: %s", line);
				errors++;
			end
		end
		$fclose(fd);
		fifo = aud_words;
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic run_key(input key_rec_t k);
		int stb_count;
		stb_count = 0;
		@(negedge CLK_114);
		clk7_en = 1'b0;
		case (k.mode)
			2'd0: begin
				c64_key = k.key_a;
				c64_key_stb = 1'b1;
			end
			2'd1: begin
				amiga_key = k.key_a;
				amiga_key_stb = 1'b1;
			end
			2'd2: begin
				c64_key = k.key_a;
				amiga_key = k.key_b;
				c64_key_stb = 1'b1;
				amiga_key_stb = 1'b1;
			end
			default: begin                          // Second key overwrites first
				c64_key = k.key_a;
				c64_key_stb = 1'b1;
				@(negedge CLK_114);
				c64_key_stb = 1'b0;
				amiga_key = k.key_b;
				amiga_key_stb = 1'b1;
			end
		endcase
		@(negedge CLK_114);
		c64_key_stb = 1'b0;
		amiga_key_stb = 1'b0;
		repeat (k.delay) begin
			@(negedge CLK_114);
			if (kbd_stb)
				stb_count++;                         // Early strobe before the enable edge
		end
		clk7_en = 1'b1;
		repeat (32) begin
			@(negedge CLK_114);
			clk7_en = 1'b0;
			if (kbd_stb) begin
				stb_count++;
				compare_value("kbd_data", k.expected, kbd_data);
			end
		end
		checks++;
		assert (stb_count == 1) else begin
			errors++;
			$display("Key %h gave %0d strobes on kbd_stb instead of one", k.expected, stb_count);
		end
	endtask

	task automatic run_vid(input vid_rec_t v);
		minimig_glue_pkg::sync_t exp_sync;
		exp_sync.hs = v.sync.hs ^ v.hpol;
		exp_sync.vs = v.sync.vs ^ v.vpol;
		@(negedge CLK_114);
		vid_rgb = v.rgb;
		vid_sync = v.sync;
		osd_window = v.window;
		osd_pixel = v.pixel;
		scan_15k = v.scan_15k;
		hsyncpol = v.hpol;
		vsyncpol = v.vpol;
		for (int c = 1; c <= 16; c++) begin
			@(negedge CLK_114);
			if (c == 1 && v.hpol == prev_hpol && v.vpol == prev_vpol)
				compare_value("vga_sync", prev_sync, vga_sync);   // Old sync still out
			if (c >= 2)
				compare_value("vga_sync", exp_sync, vga_sync);
		end
		compare_value("vga_rgb", expected_vga(v), vga_rgb);
		prev_sync = exp_sync;
		prev_hpol = v.hpol;
		prev_vpol = v.vpol;
	endtask

	task automatic check_pixel_rate(input logic mode_15k);
		int pulses;
		pulses = 0;
		@(negedge CLK_114);
		scan_15k = mode_15k;
		repeat (16) @(negedge CLK_114);          // Divider settles after mode change
		repeat (64) begin
			@(negedge CLK_114);
			if (vga_pixel_ena)
				pulses++;
		end
		compare_value("vga_pixel_ena count", mode_15k ? 64 / minimig_glue_pkg::PIX_DIV_15K :
			64 / minimig_glue_pkg::PIX_DIV_31K, pulses);
	endtask

	task automatic check_audio();
		int last_left;
		int left_cyc;
		int right_cyc;
		last_left = release_cycle;
		for (int f = 0; f < aud_words.size() / 2; f++) begin
			do @(negedge CLK_114); while (!aud_next);
			left_cyc = cycle;
			compare_value("aud_next frame spacing", minimig_glue_pkg::AUD_FRAME_CYCLES,
				left_cyc - last_left);
			do @(negedge CLK_114); while (!aud_next);
			right_cyc = cycle;
			compare_value("aud_next gap", minimig_glue_pkg::AUD_GAP_CYCLES, right_cyc - left_cyc);
			@(negedge CLK_114);                      // Right half lands one cycle later
			compare_value("aud_out", {swap_bytes(aud_words[2 * f]),
				swap_bytes(aud_words[2 * f + 1])}, aud_out);
			last_left = left_cyc;
		end
	endtask

	initial begin : watchdog
		wait (trace_loaded);
		repeat (limit) @(posedge CLK_114);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("Test failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		c64_key = '0;
		c64_key_stb = 1'b0;
		amiga_key = '0;
		amiga_key_stb = 1'b0;
		clk7_en = 1'b0;
		vid_rgb = '0;
		vid_sync = '0;
		osd_window = 1'b0;
		osd_pixel = 1'b0;
		scan_15k = 1'b0;
		hsyncpol = 1'b0;
		vsyncpol = 1'b0;
		load_trace();
		limit = (aud_words.size() / 2) * minimig_glue_pkg::AUD_FRAME_CYCLES +
			vids.size() * 16 + keys.size() * 32 + 200;
		trace_loaded = 1'b1;
		repeat (16) @(negedge CLK_114);
		rst_n = 1'b1;
		release_cycle = cycle;
		if (trace_ok) begin
			fork
				check_audio();                       // Pacer runs free from reset
				begin
					foreach (keys[i])
						run_key(keys[i]);
					foreach (vids[i])
						run_vid(vids[i]);
					check_pixel_rate(1'b0);
					check_pixel_rate(1'b1);
				end
			join
		end
		errors += u_dut.u_assertions.failures;   // Bound property failures
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: testbench/glue_trace.txt
# key <mode 0=c64 1=amiga 2=both 3=c64 then amiga> <key a> <key b> <cycles to clk7_en rise> <expected code>
# aud <left word> <right word>, one stereo frame per line, FIFO order
# vid <rgb hex> <hs> <vs> <window> <pixel> <scan_15k> <hsyncpol> <vsyncpol>
key 0 45 00 3 45
key 1 2a 00 7 2a
key 2 11 62 2 11
key 3 20 33 5 33
key 1 7f 00 1 7f
key 3 0c 4d 9 4d
aud 1234 abcd
aud 00ff ff00
aud 5a96 c33c
vid a5c3e7 1 0 0 0 0 0 0
vid a5c3e7 1 0 1 1 0 0 0
vid 3f81fe 0 1 1 0 0 0 0
vid 3f81fe 0 1 1 0 1 0 0
vid 12f0ab 1 1 0 1 1 1 0
vid 12f0ab 0 0 1 1 1 1 1
vid ffffff 1 0 1 0 0 1 1
vid 000000 0 1 1 0 0 0 1

// File: project.f
common/minimig_glue_pkg.sv
keyboard/kbd_event_merge.sv
audio/aux_audio_pacer.sv
video/osd_overlay.sv
video/vga_output_stage.sv
verilog/minimig_glue_top.sv
testbench/minimig_glue_assertions.sv
testbench/tb_minimig_glue.sv
